//--- flist.f
rtl/biquad_pkg.sv
rtl/biquad_ifs.sv
rtl/coef_regs_apb.sv
rtl/sample_history.sv
rtl/mac16_accum.sv
rtl/biquad_sequencer.sv
rtl/output_stage.sv
rtl/biquad_top.sv
verification/tb_clock_gen.sv
verification/tb_biquad.sv

//--- rtl/biquad_ifs.sv
// ********************
// Biquad internal buses
// Coefficient/event bus and sample history bus
// ********************
`timescale 1ns/1ps

interface coef_if;
    biquad_pkg::sample_t b0;
    biquad_pkg::sample_t b1;
    biquad_pkg::sample_t b2;
    biquad_pkg::sample_t a1;
    biquad_pkg::sample_t a2;
    logic                enable;
    logic                overrun_evt;   // One-cycle pulse from sequencer
    logic                clip_evt;      // One-cycle pulse from output stage

    modport regs (output b0, b1, b2, a1, a2, enable, input overrun_evt, clip_evt);
    modport seq  (input b0, b1, b2, a1, a2, enable, output overrun_evt);
    modport out  (output clip_evt);
endinterface

interface hist_if;
    biquad_pkg::sample_t x0;   // x[n]
    biquad_pkg::sample_t x1;   // x[n-1]
    biquad_pkg::sample_t x2;   // x[n-2]
    logic                start;

    modport src (output x0, x1, x2, start);
    modport dst (input x0, x1, x2, start);
endinterface

//--- rtl/biquad_pkg.sv
// ********************
// Biquad shared definitions
// Widths, Q2.14 format, APB register map and sequencer states
// ********************
package biquad_pkg;

    parameter int SAMPLE_W  = 16;   // Audio samples and coefficients
    parameter int ACC_W     = 32;   // MAC accumulator
    parameter int COEF_FRAC = 14;   // Q2.14 coefficients

    // APB byte offsets
    parameter logic [7:0] REG_B0     = 8'h00;
    parameter logic [7:0] REG_B1     = 8'h04;
    parameter logic [7:0] REG_B2     = 8'h08;
    parameter logic [7:0] REG_A1     = 8'h0C;
    parameter logic [7:0] REG_A2     = 8'h10;
    parameter logic [7:0] REG_CTRL   = 8'h14;   // Bit 0 enable
    parameter logic [7:0] REG_STATUS = 8'h18;   // Bit 0 overrun, bit 1 clip

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // One state per MAC product, then a pipeline drain
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        MULT_B0 = 3'd1,
        MULT_B1 = 3'd2,
        MULT_B2 = 3'd3,
        MULT_A1 = 3'd4,
        MULT_A2 = 3'd5,
        DRAIN   = 3'd6
    } seq_state_t;

endpackage

//--- rtl/biquad_sequencer.sv
// ********************
// Biquad MAC sequencer
// Steps the shared MAC through b0, b1, b2, -a1, -a2
// and keeps the y history
// ********************
`timescale 1ns/1ps

module biquad_sequencer (
    input  logic                clk,
    input  logic                reset,
    coef_if.seq                 coef,
    hist_if.dst                 hist,
    input  logic                sample_valid,
    output logic                busy,
    output biquad_pkg::sample_t mac_a,
    output biquad_pkg::sample_t mac_b,
    output logic                mac_ce,
    output logic                mac_clr,
    output logic                acc_done,
    input  biquad_pkg::sample_t y_sat,
    input  logic                out_valid
);

    biquad_pkg::seq_state_t state;
    biquad_pkg::seq_state_t next_state;
    biquad_pkg::sample_t    b0_q;
    biquad_pkg::sample_t    b1_q;
    biquad_pkg::sample_t    b2_q;
    biquad_pkg::sample_t    a1_neg;   // Feedback terms stored negated
    biquad_pkg::sample_t    a2_neg;
    biquad_pkg::sample_t    y1;       // y[n-1]
    biquad_pkg::sample_t    y2;       // y[n-2]
    logic                   take;

    assign take             = sample_valid && coef.enable;
    assign coef.overrun_evt = take && busy;   // Dropped sample
    assign mac_clr          = (state == biquad_pkg::IDLE) && hist.start;
    assign mac_ce           = state inside {biquad_pkg::MULT_B0, biquad_pkg::MULT_B1,
                                            biquad_pkg::MULT_B2, biquad_pkg::MULT_A1,
                                            biquad_pkg::MULT_A2};

    // Busy from acceptance until the result leaves
    always_ff @(posedge clk) begin
        if (!reset) begin
            busy <= 1'b0;
        end else if (take && !busy) begin
            busy <= 1'b1;
        end else if (out_valid) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state    <= biquad_pkg::IDLE;
            acc_done <= 1'b0;
        end else begin
            state    <= next_state;
            acc_done <= (state == biquad_pkg::DRAIN);   // Last product is summed now
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            biquad_pkg::IDLE:    if (hist.start) next_state = biquad_pkg::MULT_B0;
            biquad_pkg::MULT_B0: next_state = biquad_pkg::MULT_B1;
            biquad_pkg::MULT_B1: next_state = biquad_pkg::MULT_B2;
            biquad_pkg::MULT_B2: next_state = biquad_pkg::MULT_A1;
            biquad_pkg::MULT_A1: next_state = biquad_pkg::MULT_A2;
            biquad_pkg::MULT_A2: next_state = biquad_pkg::DRAIN;
            default:             next_state = biquad_pkg::IDLE;
        endcase
    end

    // Coefficients frozen for the whole sample
    always_ff @(posedge clk) begin
        if (!reset) begin
            b0_q   <= '0;
            b1_q   <= '0;
            b2_q   <= '0;
            a1_neg <= '0;
            a2_neg <= '0;
        end else if (mac_clr) begin
            b0_q   <= coef.b0;
            b1_q   <= coef.b1;
            b2_q   <= coef.b2;
            a1_neg <= -coef.a1;
            a2_neg <= -coef.a2;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            y1 <= '0;
            y2 <= '0;
        end else if (out_valid) begin
            y2 <= y1;
            y1 <= y_sat;   // Clamped output feeds back
        end
    end

    always_comb begin
        case (state)
            biquad_pkg::MULT_B0: begin mac_a = b0_q;   mac_b = hist.x0; end
            biquad_pkg::MULT_B1: begin mac_a = b1_q;   mac_b = hist.x1; end
            biquad_pkg::MULT_B2: begin mac_a = b2_q;   mac_b = hist.x2; end
            biquad_pkg::MULT_A1: begin mac_a = a1_neg; mac_b = y1;      end
            biquad_pkg::MULT_A2: begin mac_a = a2_neg; mac_b = y2;      end
            default:             begin mac_a = '0;     mac_b = '0;      end
        endcase
    end

    // MAC runs only inside the busy interval, with no new start pending
    mac_window_chk: assert property (@(posedge clk) disable iff (!reset)
        mac_ce |-> (busy && !hist.start))
        else $error("MAC enable outside the busy interval, state=%0d", state);

endmodule

//--- rtl/biquad_top.sv
// ********************
// Biquad IIR filter top
// APB coefficient port, audio in, filtered audio out
// ********************
`timescale 1ns/1ps

module biquad_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [7:0]          paddr,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    input  biquad_pkg::sample_t sample_in,
    input  logic                sample_valid,
    output biquad_pkg::sample_t out_data,
    output logic                out_valid
);

    logic                                busy;
    biquad_pkg::sample_t                 mac_a;
    biquad_pkg::sample_t                 mac_b;
    logic                                mac_ce;
    logic                                mac_clr;
    logic signed [biquad_pkg::ACC_W-1:0] acc;
    logic                                acc_done;
    biquad_pkg::sample_t                 y_sat;

    coef_if coef_bus ();
    hist_if hist_bus ();

    coef_regs_apb coef_regs_apb_inst (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .coef    (coef_bus.regs)
    );

    sample_history sample_history_inst (
        .clk          (clk),
        .reset        (reset),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .busy         (busy),
        .enable       (coef_bus.enable),
        .hist         (hist_bus.src)
    );

    biquad_sequencer biquad_sequencer_inst (
        .clk          (clk),
        .reset        (reset),
        .coef         (coef_bus.seq),
        .hist         (hist_bus.dst),
        .sample_valid (sample_valid),
        .busy         (busy),
        .mac_a        (mac_a),
        .mac_b        (mac_b),
        .mac_ce       (mac_ce),
        .mac_clr      (mac_clr),
        .acc_done     (acc_done),
        .y_sat        (y_sat),
        .out_valid    (out_valid)
    );

    mac16_accum mac16_accum_inst (
        .clk   (clk),
        .reset (reset),
        .clr   (mac_clr),
        .ce    (mac_ce),
        .a     (mac_a),
        .b     (mac_b),
        .acc   (acc)
    );

    output_stage output_stage_inst (
        .clk       (clk),
        .reset     (reset),
        .acc       (acc),
        .acc_done  (acc_done),
        .coef      (coef_bus.out),
        .out_data  (out_data),
        .out_valid (out_valid),
        .y_sat     (y_sat)
    );

endmodule

//--- rtl/coef_regs_apb.sv
// ********************
// APB coefficient register block
// Five Q2.14 coefficients, CTRL enable and sticky STATUS bits
// ********************
`timescale 1ns/1ps

module coef_regs_apb (
    input  logic        clk,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    coef_if.regs        coef
);

    logic       access;
    logic       wr_en;
    logic       mapped;
    logic [1:0] status;       // [1] clip, [0] overrun
    logic [1:0] status_clr;   // Write-one-to-clear mask

    assign access  = psel && penable;   // Access phase
    assign wr_en   = access && pwrite;
    assign pready  = 1'b1;              // No wait states
    assign pslverr = access && !mapped;

    // Read mux and address decode
    always_comb begin
        mapped = 1'b1;
        prdata = '0;
        case (paddr)
            biquad_pkg::REG_B0:     prdata[biquad_pkg::SAMPLE_W-1:0] = coef.b0;
            biquad_pkg::REG_B1:     prdata[biquad_pkg::SAMPLE_W-1:0] = coef.b1;
            biquad_pkg::REG_B2:     prdata[biquad_pkg::SAMPLE_W-1:0] = coef.b2;
            biquad_pkg::REG_A1:     prdata[biquad_pkg::SAMPLE_W-1:0] = coef.a1;
            biquad_pkg::REG_A2:     prdata[biquad_pkg::SAMPLE_W-1:0] = coef.a2;
            biquad_pkg::REG_CTRL:   prdata[0] = coef.enable;
            biquad_pkg::REG_STATUS: prdata[1:0] = status;
            default:                mapped = 1'b0;   // Reads back zero
        endcase
    end

    assign status_clr = (wr_en && paddr == biquad_pkg::REG_STATUS) ? pwdata[1:0] : 2'b00;

    always_ff @(posedge clk) begin
        if (!reset) begin
            coef.b0     <= '0;
            coef.b1     <= '0;
            coef.b2     <= '0;
            coef.a1     <= '0;
            coef.a2     <= '0;
            coef.enable <= 1'b0;
            status      <= 2'b00;
        end else begin
            if (wr_en) begin
                case (paddr)
                    biquad_pkg::REG_B0:   coef.b0 <= pwdata[biquad_pkg::SAMPLE_W-1:0];
                    biquad_pkg::REG_B1:   coef.b1 <= pwdata[biquad_pkg::SAMPLE_W-1:0];
                    biquad_pkg::REG_B2:   coef.b2 <= pwdata[biquad_pkg::SAMPLE_W-1:0];
                    biquad_pkg::REG_A1:   coef.a1 <= pwdata[biquad_pkg::SAMPLE_W-1:0];
                    biquad_pkg::REG_A2:   coef.a2 <= pwdata[biquad_pkg::SAMPLE_W-1:0];
                    biquad_pkg::REG_CTRL: coef.enable <= pwdata[0];
                    default: ;
                endcase
            end
            // New events win over a clear in the same cycle
            status <= (status & ~status_clr) | {coef.clip_evt, coef.overrun_evt};
        end
    end

    apb_handshake_chk: assert property (@(posedge clk) disable iff (!reset)
        pready && (!penable || psel))
        else $error("APB handshake broken: pready=%b penable=%b psel=%b",
                    pready, penable, psel);

endmodule

//--- rtl/mac16_accum.sv
// ********************
// 16x16 signed MAC
// Registered product feeding a wrapping 32-bit accumulator
// ********************
`timescale 1ns/1ps

module mac16_accum (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                clr,   // Zeroes product and sum
    input  logic                                ce,
    input  biquad_pkg::sample_t                 a,     // Coefficient
    input  biquad_pkg::sample_t                 b,     // Data
    output logic signed [biquad_pkg::ACC_W-1:0] acc
);

    logic signed [biquad_pkg::ACC_W-1:0] prod;
    logic                                prod_vld;   // prod holds a fresh term

    always_ff @(posedge clk) begin
        if (!reset || clr) begin
            prod     <= '0;
            prod_vld <= 1'b0;
            acc      <= '0;
        end else begin
            prod_vld <= ce;
            if (ce) begin
                prod <= biquad_pkg::ACC_W'(a) * biquad_pkg::ACC_W'(b);
            end
            if (prod_vld) begin
                acc <= acc + prod;   // Wraps at ACC_W
            end
        end
    end

endmodule

//--- rtl/output_stage.sv
// ********************
// Biquad output stage
// Q2.14 rescale with saturation, valid pulse and clip event
// ********************
`timescale 1ns/1ps

module output_stage (
    input  logic                                clk,
    input  logic                                reset,
    input  logic signed [biquad_pkg::ACC_W-1:0] acc,
    input  logic                                acc_done,
    coef_if.out                                 coef,
    output biquad_pkg::sample_t                 out_data,
    output logic                                out_valid,
    output biquad_pkg::sample_t                 y_sat      // Back to the y history
);

    localparam int SAT_MAX = 2 ** (biquad_pkg::SAMPLE_W - 1) - 1;
    localparam int SAT_MIN = -(2 ** (biquad_pkg::SAMPLE_W - 1));

    logic signed [biquad_pkg::ACC_W-1:0] scaled;
    biquad_pkg::sample_t                 clamped;
    logic                                clip;

    assign scaled = acc >>> biquad_pkg::COEF_FRAC;   // Floor toward -inf

    always_comb begin
        clip = 1'b1;
        if (scaled > SAT_MAX) begin
            clamped = biquad_pkg::sample_t'(SAT_MAX);
        end else if (scaled < SAT_MIN) begin
            clamped = biquad_pkg::sample_t'(SAT_MIN);
        end else begin
            clip    = 1'b0;
            clamped = scaled[biquad_pkg::SAMPLE_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            out_valid     <= 1'b0;
            coef.clip_evt <= 1'b0;
        end else begin
            out_valid     <= acc_done;
            coef.clip_evt <= acc_done && clip;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_done) begin
            out_data <= clamped;
        end
    end

    assign y_sat = out_data;

endmodule

//--- rtl/sample_history.sv
// ********************
// Sample history stage
// Accepts input samples and shifts x[n], x[n-1], x[n-2]
// ********************
`timescale 1ns/1ps

module sample_history (
    input  logic                clk,
    input  logic                reset,
    input  biquad_pkg::sample_t sample_in,
    input  logic                sample_valid,
    input  logic                busy,      // From sequencer
    input  logic                enable,    // CTRL bit 0
    hist_if.src                 hist
);

    logic accept;
    logic shifted;   // History moved on the last edge

    // Only place where a sample is taken in
    assign accept = sample_valid && enable && !busy;

    always_ff @(posedge clk) begin
        if (!reset) begin
            hist.x0    <= '0;
            hist.x1    <= '0;
            hist.x2    <= '0;
            shifted    <= 1'b0;
            hist.start <= 1'b0;
        end else begin
            if (accept) begin
                hist.x2 <= hist.x1;
                hist.x1 <= hist.x0;
                hist.x0 <= sample_in;
            end
            shifted    <= accept;
            hist.start <= shifted;   // One cycle after the shift
        end
    end

    start_pulse_chk: assert property (@(posedge clk) disable iff (!reset)
        hist.start |=> !hist.start)
        else $error("start held high for two cycles");

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the biquad testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_biquad -f flist.f -o tb_biquad_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_biquad_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi
exit 0

//--- verification/tb_biquad.sv
// ********************
// Biquad filter testbench
// APB and audio stimulus, reference model, assertion checks
// ********************
`timescale 1ns/1ps

module tb_biquad;

    localparam int N_PASS          = 16;
    localparam int N_GEN           = 64;
    localparam int N_SAT           = 8;
    localparam int N_OTHER         = 5;   // Overrun and disable phases
    localparam int NUM_SAMPLES     = N_PASS + N_GEN + N_SAT + N_OTHER;
    localparam int WATCHDOG_CYCLES = NUM_SAMPLES * 12 + 200;
    localparam int OUT_WAIT_MAX    = 20;

    logic                clk;
    logic                reset;
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [7:0]          paddr;
    logic [31:0]         pwdata;
    logic [31:0]         prdata;
    logic                pready;
    logic                pslverr;
    biquad_pkg::sample_t sample_in;
    logic                sample_valid;
    biquad_pkg::sample_t out_data;
    logic                out_valid;

    integer seed;
    int     error_count;
    int     out_count;

    biquad_pkg::sample_t cb0, cb1, cb2, ca1, ca2;   // Coefficients the DUT holds
    biquad_pkg::sample_t mx0, mx1, mx2;             // Model x history
    biquad_pkg::sample_t my1, my2;                  // Model y history
    biquad_pkg::sample_t exp_data;
    logic [1:0]          exp_status;
    logic [31:0]         exp_rdata;
    logic                exp_slverr;
    logic                sample_expected;   // Sample should be accepted

    tb_clock_gen clock_gen_inst (.clk(clk));

    biquad_top biquad_top_inst (
        .clk          (clk),
        .reset        (reset),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .out_data     (out_data),
        .out_valid    (out_valid)
    );

    out_data_chk: assert property (@(posedge clk) disable iff (!reset)
        out_valid |-> out_data == exp_data)
        else begin
            error_count = error_count + 1;
            $display("[ERROR] out_data got 0x%h expected 0x%h", $sampled(out_data), exp_data);
        end

    // Rises on edge 9 after acceptance, so it is sampled high on edge 10
    latency_chk: assert property (@(posedge clk) disable iff (!reset)
        out_valid == $past(sample_expected, 10))
        else begin
            error_count = error_count + 1;
            $display("[ERROR] out_valid got 0x%h expected 0x%h",
                     $sampled(out_valid), $past(sample_expected, 10));
        end

    prdata_chk: assert property (@(posedge clk) disable iff (!reset)
        (psel && penable && !pwrite) |-> prdata == exp_rdata)
        else begin
            error_count = error_count + 1;
            $display("[ERROR] prdata at 0x%h got 0x%h expected 0x%h",
                     $sampled(paddr), $sampled(prdata), exp_rdata);
        end

    pslverr_chk: assert property (@(posedge clk) disable iff (!reset)
        (psel && penable) |-> (pslverr == exp_slverr && pready))
        else begin
            error_count = error_count + 1;
            $display("[ERROR] pslverr at 0x%h got 0x%h expected 0x%h",
                     $sampled(paddr), $sampled(pslverr), exp_slverr);
        end

    // Five-term sum, 32-bit wrap, floor shift, clamp, clamped y fed back
    task automatic model_step(input biquad_pkg::sample_t x);
        int sum;
        int scaled;
        mx2 = mx1;
        mx1 = mx0;
        mx0 = x;
        sum = int'(cb0) * int'(mx0) + int'(cb1) * int'(mx1) + int'(cb2) * int'(mx2)
            - int'(ca1) * int'(my1) - int'(ca2) * int'(my2);
        scaled = sum >>> biquad_pkg::COEF_FRAC;
        if (scaled > 32767) begin
            exp_data      = 16'sh7FFF;
            exp_status[1] = 1'b1;
        end else if (scaled < -32768) begin
            exp_data      = 16'sh8000;
            exp_status[1] = 1'b1;
        end else begin
            exp_data = biquad_pkg::sample_t'(scaled);
        end
        my2 = my1;
        my1 = exp_data;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic err);
        psel       = 1'b1;
        penable    = 1'b0;
        pwrite     = 1'b1;
        paddr      = addr;
        pwdata     = data;
        exp_slverr = err;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic [31:0] expected, input logic err);
        psel       = 1'b1;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = addr;
        exp_rdata  = expected;
        exp_slverr = err;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic set_coefs(input biquad_pkg::sample_t b0, input biquad_pkg::sample_t b1,
                             input biquad_pkg::sample_t b2, input biquad_pkg::sample_t a1,
                             input biquad_pkg::sample_t a2);
        cb0 = b0;
        cb1 = b1;
        cb2 = b2;
        ca1 = a1;
        ca2 = a2;
        apb_write(biquad_pkg::REG_B0, {16'h0000, b0}, 1'b0);
        apb_write(biquad_pkg::REG_B1, {16'h0000, b1}, 1'b0);
        apb_write(biquad_pkg::REG_B2, {16'h0000, b2}, 1'b0);
        apb_write(biquad_pkg::REG_A1, {16'h0000, a1}, 1'b0);
        apb_write(biquad_pkg::REG_A2, {16'h0000, a2}, 1'b0);
    endtask

    task automatic read_status();
        apb_read(biquad_pkg::REG_STATUS, {30'd0, exp_status}, 1'b0);
    endtask

    task automatic clear_status(input logic [1:0] bits);
        apb_write(biquad_pkg::REG_STATUS, {30'd0, bits}, 1'b0);
        exp_status = exp_status & ~bits;
    endtask

    function automatic biquad_pkg::sample_t small_coef(input int limit);
        return biquad_pkg::sample_t'($random(seed) % limit);
    endfunction

    // Optionally pokes a second sample into the busy interval
    task automatic send_sample(input biquad_pkg::sample_t s, input logic inject_overrun);
        int waited;
        model_step(s);
        sample_in       = s;
        sample_valid    = 1'b1;
        sample_expected = 1'b1;
        @(negedge clk);
        sample_valid    = 1'b0;
        sample_expected = 1'b0;
        if (inject_overrun) begin
            repeat (3) @(negedge clk);
            sample_in     = ~s;
            sample_valid  = 1'b1;
            exp_status[0] = 1'b1;
            @(negedge clk);
            sample_valid = 1'b0;
        end
        waited = 0;
        while (!out_valid && waited < OUT_WAIT_MAX) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (out_valid) begin
            out_count = out_count + 1;
        end else begin
            error_count = error_count + 1;
            $display("No out_valid arrived for input sample 0x%h", s);
        end
        @(negedge clk);   // Busy drops on the next edge
    endtask

    task automatic drive_ignored(input biquad_pkg::sample_t s);
        sample_in    = s;
        sample_valid = 1'b1;
        @(negedge clk);
        sample_valid = 1'b0;
        repeat (12) @(negedge clk);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Simulation timed out after %0d clock cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        seed            = 32'h2e7a_e7f8;
        error_count     = 0;
        out_count       = 0;
        reset           = 1'b0;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        paddr           = '0;
        pwdata          = '0;
        sample_in       = '0;
        sample_valid    = 1'b0;
        sample_expected = 1'b0;
        {cb0, cb1, cb2, ca1, ca2} = '0;
        {mx0, mx1, mx2, my1, my2} = '0;
        exp_data        = '0;
        exp_status      = 2'b00;
        exp_rdata       = '0;
        exp_slverr      = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;

        // Register write and read-back, unmapped address
        set_coefs(16'sh1234, 16'sh0567, -16'sh0089, 16'sh0ABC, -16'sh0DEF);
        apb_write(biquad_pkg::REG_CTRL, 32'h0000_0001, 1'b0);
        apb_read(biquad_pkg::REG_B0, {16'h0000, cb0}, 1'b0);
        apb_read(biquad_pkg::REG_B1, {16'h0000, cb1}, 1'b0);
        apb_read(biquad_pkg::REG_B2, {16'h0000, cb2}, 1'b0);
        apb_read(biquad_pkg::REG_A1, {16'h0000, ca1}, 1'b0);
        apb_read(biquad_pkg::REG_A2, {16'h0000, ca2}, 1'b0);
        apb_read(biquad_pkg::REG_CTRL, 32'h0000_0001, 1'b0);
        apb_write(8'h1C, 32'hDEAD_BEEF, 1'b1);
        apb_read(8'h1C, 32'h0000_0000, 1'b1);

        // Unity gain through b0
        set_coefs(16'sh4000, 16'sh0000, 16'sh0000, 16'sh0000, 16'sh0000);
        for (int i = 0; i < N_PASS; i++) begin
            send_sample(biquad_pkg::sample_t'($random(seed)), 1'b0);
        end

        // Full biquad with feedback
        set_coefs(small_coef(4096), small_coef(4096), small_coef(4096),
                  small_coef(2048), small_coef(2048));
        for (int i = 0; i < N_GEN; i++) begin
            send_sample(biquad_pkg::sample_t'($random(seed)), 1'b0);
        end

        // Dropped sample must leave the history alone
        clear_status(2'b11);
        send_sample(biquad_pkg::sample_t'($random(seed)), 1'b1);
        send_sample(biquad_pkg::sample_t'($random(seed)), 1'b0);
        read_status();
        clear_status(2'b11);
        read_status();

        // Saturation at full scale
        set_coefs(16'sh7FFF, 16'sh0000, 16'sh0000, 16'sh0000, 16'sh0000);
        for (int i = 0; i < N_SAT; i++) begin
            send_sample(i[0] ? 16'sh8000 : 16'sh7FFF, 1'b0);
        end
        read_status();
        clear_status(2'b10);
        read_status();

        // Filter disabled
        apb_write(biquad_pkg::REG_CTRL, 32'h0000_0000, 1'b0);
        drive_ignored(16'sh1111);
        drive_ignored(-16'sh2222);
        read_status();
        apb_read(biquad_pkg::REG_CTRL, 32'h0000_0000, 1'b0);

        @(negedge clk);
        $display("Checks done: %0d outputs, %0d errors", out_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- verification/tb_clock_gen.sv
// ********************
// Testbench clock generator
// 100 ns period, starts low
// ********************
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    localparam int HALF_PERIOD_NS = 50;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule
